// ==== build.f ====
hdl/performan_pkg.sv
hdl/bus_decode.sv
hdl/video_timing.sv
hdl/pixel_mixer.sv
hdl/performan_video_top.sv
tb/performan_properties.sv
tb/performan_tb.sv

// ==== Bender.yml ====
package:
  name: performan_video

sources:
  - files:
      - hdl/performan_pkg.sv
      - hdl/bus_decode.sv
      - hdl/video_timing.sv
      - hdl/pixel_mixer.sv
      - hdl/performan_video_top.sv
  - target: test
    files:
      - tb/performan_properties.sv
      - tb/performan_tb.sv

// ==== tb/performan_tb.sv ====
`timescale 1ns/10ps

module performan_tb import performan_pkg::*; ();

	localparam int FRAME_CYCLES = int'(H_TOTAL) * int'(V_TOTAL);

	logic   pixel_clk;
	logic   RESET_n;
	addr_t  bus_addr;
	data_t  bus_data;
	logic   mem_wr;
	logic   io_wr;
	pixel_t sp_pixel;
	pixel_t bg_pixel;
	pixel_t colour;
	hpix_t  hpix_scrl;
	vpix_t  vpix;
	logic   h_sync, h_blank, v_sync, v_blank, irq;

	// Reference model state
	int     m_hcount, m_vcount;
	data_t  m_hscroll;
	logic   m_flip, m_int_en, m_irq;
	hpix_t  m_hpix_scrl;
	pixel_t m_colour;

	logic [31:0] lfsr_state;
	logic        latch_rand_en;  // Random writes may hit flip and int_enable
	logic        dir_pending;    // Directed write waiting for the next edge
	logic        dir_mem;
	addr_t       dir_addr;
	data_t       dir_data;
	int          irq_rises;
	logic        irq_seen;

	performan_video_top uut (
		.pixel_clk   (pixel_clk),
		.RESET_n     (RESET_n),
		.bus_addr_i  (bus_addr),
		.bus_data_i  (bus_data),
		.mem_wr_i    (mem_wr),
		.io_wr_i     (io_wr),
		.sp_pixel_i  (sp_pixel),
		.bg_pixel_i  (bg_pixel),
		.colour_o    (colour),
		.hpix_scrl_o (hpix_scrl),
		.vpix_o      (vpix),
		.h_sync_o    (h_sync),
		.h_blank_o   (h_blank),
		.v_sync_o    (v_sync),
		.v_blank_o   (v_blank),
		.irq_o       (irq)
	);

	bind performan_video_top performan_properties u_props (
		.pixel_clk    (pixel_clk),
		.RESET_n      (RESET_n),
		.h_sync_i     (h_sync_o),
		.h_blank_i    (h_blank_o),
		.v_sync_i     (v_sync_o),
		.v_blank_i    (v_blank_o),
		.irq_i        (irq_o),
		.int_enable_i (int_enable),
		.hpix_i       (hpix),
		.colour_i     (colour_o)
	);

	always #50 pixel_clk = ~pixel_clk;

	// ====================
	// Reporting and compare
	// ====================
	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic hpix_compare(input string name, input hpix_t act, input hpix_t exp);
		if (act !== exp)
			report_failure($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, act, exp));
	endtask

	task automatic vpix_compare(input string name, input vpix_t act, input vpix_t exp);
		if (act !== exp)
			report_failure($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, act, exp));
	endtask

	task automatic pixel_compare(input string name, input pixel_t act, input pixel_t exp);
		if (act !== exp)
			report_failure($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, act, exp));
	endtask

	task automatic bit_compare(input string name, input logic act, input logic exp);
		if (act !== exp)
			report_failure($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, act, exp));
	endtask

	// ====================
	// Random source
	// ====================
	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_advance(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[31]};
			lfsr_state = lfsr_advance(lfsr_state);
		end
	endtask

	// ====================
	// Reference model
	// ====================
	function automatic int model_hpix();
		if (m_flip)
			return (int'(H_FLIP_BASE) - m_hcount + 512) % 512;  // Mirrored position
		return m_hcount;
	endfunction

	function automatic pixel_t model_colour(input int pos, input pixel_t sp, input pixel_t bg);
		if (pos >= int'(BORDER_LO))
			return '0;
		if (sp[2:0] != 3'd0 && (sp[7] || bg[2:0] == 3'd0))
			return {1'b1, sp[6:0]};
		return bg;
	endfunction

	// Next state from the inputs that the coming edge samples
	task automatic step_model();
		int pos;
		pos = model_hpix();
		m_hpix_scrl = hpix_t'((pos + int'(m_hscroll)) % 512);
		m_colour = model_colour(pos, sp_pixel, bg_pixel);
		if (!m_int_en)
			m_irq = 1'b0;
		else if (m_hcount == int'(H_TOTAL) - 1 && m_vcount == int'(V_BLANK_START) - 1)
			m_irq = 1'b1;
		m_hcount = m_hcount + 1;
		if (m_hcount == int'(H_TOTAL)) begin
			m_hcount = 0;
			m_vcount = (m_vcount + 1) % int'(V_TOTAL);
		end
		if (mem_wr && bus_addr[15:11] == 5'b10101 && bus_addr[1:0] == 2'b00)
			m_hscroll = bus_data;
		if (io_wr && bus_addr[3:1] == LATCH_FLIP)
			m_flip = bus_addr[0];
		if (io_wr && bus_addr[3:1] == LATCH_INT_ENABLE)
			m_int_en = bus_addr[0];
	endtask

	task automatic check_outputs();
		vpix_t v_exp;
		v_exp = m_flip ? ~vpix_t'(m_vcount) : vpix_t'(m_vcount);
		bit_compare("h_sync_o", h_sync,
			m_hcount >= int'(H_SYNC_START) && m_hcount <= int'(H_SYNC_END));
		bit_compare("h_blank_o", h_blank, m_hcount >= int'(H_BLANK_START));
		bit_compare("v_sync_o", v_sync,
			m_vcount >= int'(V_SYNC_START) && m_vcount <= int'(V_SYNC_END));
		bit_compare("v_blank_o", v_blank, m_vcount >= int'(V_BLANK_START));
		bit_compare("irq_o", irq, m_irq);
		vpix_compare("vpix_o", vpix, v_exp);
		hpix_compare("hpix_scrl_o", hpix_scrl, m_hpix_scrl);
		pixel_compare("colour_o", colour, m_colour);
	endtask

	// ====================
	// Stimulus
	// ====================
	task automatic drive_inputs();
		logic [31:0] r;
		logic [31:0] v;
		logic [2:0]  idx;
		random_bits(8, r);
		sp_pixel <= r[7:0];
		random_bits(8, r);
		bg_pixel <= r[7:0];
		mem_wr <= 1'b0;
		io_wr  <= 1'b0;
		random_bits(6, r);
		if (dir_pending) begin
			bus_addr    <= dir_addr;
			bus_data    <= dir_data;
			mem_wr      <= dir_mem;
			io_wr       <= !dir_mem;
			dir_pending = 1'b0;
		end else if (r[5:0] == 6'd0) begin  // Memory write
			random_bits(8, v);
			bus_data <= v[7:0];
			random_bits(12, v);
			if (v[11:10] == 2'b11)
				bus_addr <= MCU_PORT_BASE ^ 16'h8000;  // Outside the window
			else if (v[9])
				bus_addr <= MCU_PORT_BASE | {5'b00000, v[10:0]};  // Other window addresses
			else
				bus_addr <= MCU_PORT_BASE;
			mem_wr   <= 1'b1;
		end else if (r[5:0] == 6'd1) begin  // Latch write
			random_bits(3, v);
			if (latch_rand_en && v[1:0] != 2'b00) begin
				idx = v[2] ? LATCH_INT_ENABLE : LATCH_FLIP;
			end else begin
				random_bits(3, v);
				idx = v[2:0];
				if (idx == LATCH_FLIP || idx == LATCH_INT_ENABLE)
					idx = idx | 3'b100;  // Move to an unused bit
			end
			random_bits(1, v);
			bus_addr <= {12'h000, idx, v[0]};
			io_wr    <= 1'b1;
		end
	endtask

	task automatic run_cycle();
		@(posedge pixel_clk);
		drive_inputs();
		@(negedge pixel_clk);
		check_outputs();
		if (uut.u_props.assert_failures != 0)
			report_failure("A bound assertion failed during the run");
		if (irq && !irq_seen)
			irq_rises++;
		irq_seen = irq;
		step_model();
	endtask

	task automatic latch_write(input logic [2:0] idx, input logic val);
		dir_pending = 1'b1;
		dir_mem     = 1'b0;
		dir_addr    = {12'h000, idx, val};
		run_cycle();
	endtask

	task automatic scroll_write(input data_t val);
		dir_pending = 1'b1;
		dir_mem     = 1'b1;
		dir_addr    = MCU_PORT_BASE;
		dir_data    = val;
		run_cycle();
	endtask

	task automatic wait_vblank_entry();
		int   n;
		logic was_blank;
		n = 0;
		was_blank = 1'b1;  // Needs a real low to high step
		while (!(v_blank && !was_blank)) begin
			was_blank = v_blank;
			run_cycle();
			n++;
			if (n > FRAME_CYCLES + 16)
				report_failure("Timeout: vertical blank did not start within one frame");
		end
	endtask

	// ====================
	// Test sequence
	// ====================
	initial begin
		pixel_clk = 1'b0;
		RESET_n   = 1'b0;
		bus_addr  = '0;
		bus_data  = '0;
		mem_wr    = 1'b0;
		io_wr     = 1'b0;
		sp_pixel  = '0;
		bg_pixel  = '0;
		m_hcount = 0;
		m_vcount = 0;
		m_hscroll = '0;
		m_flip = 1'b0;
		m_int_en = 1'b0;
		m_irq = 1'b0;
		m_hpix_scrl = '0;
		m_colour = '0;
		lfsr_state = 32'd82666;
		latch_rand_en = 1'b0;
		dir_pending = 1'b0;
		dir_mem = 1'b0;
		dir_addr = '0;
		dir_data = '0;
		irq_rises = 0;
		irq_seen = 1'b0;

		repeat (4) begin
			@(negedge pixel_clk);
			check_outputs();  // Reset values
		end
		@(posedge pixel_clk);
		RESET_n <= 1'b1;
		@(negedge pixel_clk);
		check_outputs();
		step_model();

		// Flip off, interrupt on
		repeat (20) run_cycle();
		latch_write(LATCH_INT_ENABLE, 1'b1);
		latch_write(LATCH_FLIP, 1'b0);
		scroll_write(8'h5A);
		wait_vblank_entry();
		bit_compare("irq_o", irq, 1'b1);
		latch_write(LATCH_INT_ENABLE, 1'b0);
		repeat (2) run_cycle();
		bit_compare("irq_o", irq, 1'b0);
		repeat (100) run_cycle();
		latch_write(LATCH_INT_ENABLE, 1'b1);
		wait_vblank_entry();
		bit_compare("irq_o", irq, 1'b1);

		// Flip on, interrupt off for a whole frame
		latch_write(LATCH_FLIP, 1'b1);
		scroll_write(8'hC3);
		latch_write(LATCH_INT_ENABLE, 1'b0);
		wait_vblank_entry();
		bit_compare("irq_o", irq, 1'b0);

		// Random latch traffic
		latch_rand_en = 1'b1;
		latch_write(LATCH_INT_ENABLE, 1'b1);
		wait_vblank_entry();

		if (irq_rises < 2)
			report_failure("Fewer than two interrupt rises were seen");
		else begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

// ==== tb/performan_properties.sv ====
`timescale 1ns/10ps

module performan_properties import performan_pkg::*; (
	input logic   pixel_clk,
	input logic   RESET_n,
	input logic   h_sync_i,
	input logic   h_blank_i,
	input logic   v_sync_i,
	input logic   v_blank_i,
	input logic   irq_i,
	input logic   int_enable_i,  // Latch bit inside the top level
	input hpix_t  hpix_i,        // Flipped position inside the top level
	input pixel_t colour_i
);

	int hsync_fails = 0;
	int vsync_fails = 0;
	int irq_fails = 0;
	int border_fails = 0;
	int assert_failures;

	assign assert_failures = hsync_fails + vsync_fails + irq_fails + border_fails;

	// ====================
	// Sync inside blank
	// ====================
	hsync_in_hblank: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		h_sync_i |-> h_blank_i)
	else begin
		hsync_fails++;
		$error("h_sync_o high outside h_blank_o");
	end

	vsync_in_vblank: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		v_sync_i |-> v_blank_i)
	else begin
		vsync_fails++;
		$error("v_sync_o high outside v_blank_o");
	end

	// ====================
	// Interrupt and border
	// ====================
	irq_needs_enable: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		!int_enable_i |=> !irq_i)
	else begin
		irq_fails++;
		$error("irq_o high one cycle after int_enable was low");
	end

	border_is_black: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		(hpix_i >= BORDER_LO) |=> (colour_i == '0))
	else begin
		border_fails++;
		$error("colour_o not zero after a border position");
	end

endmodule

// ==== hdl/performan_video_top.sv ====
`timescale 1ns/10ps

module performan_video_top import performan_pkg::*; (
	input  logic   pixel_clk,
	input  logic   RESET_n,
	// CPU side
	input  addr_t  bus_addr_i,
	input  data_t  bus_data_i,
	input  logic   mem_wr_i,
	input  logic   io_wr_i,
	// Layer pixels
	input  pixel_t sp_pixel_i,
	input  pixel_t bg_pixel_i,
	// Video out
	output pixel_t colour_o,
	output hpix_t  hpix_scrl_o,
	output vpix_t  vpix_o,
	output logic   h_sync_o,
	output logic   h_blank_o,
	output logic   v_sync_o,
	output logic   v_blank_o,
	output logic   irq_o
);

	data_t h_scroll;
	logic  flip;
	logic  int_enable;
	hpix_t hpix;

	// ====================
	// Decode
	// ====================
	bus_decode u_decode (
		.pixel_clk    (pixel_clk),
		.RESET_n      (RESET_n),
		.bus_addr_i   (bus_addr_i),
		.bus_data_i   (bus_data_i),
		.mem_wr_i     (mem_wr_i),
		.io_wr_i      (io_wr_i),
		.h_scroll_o   (h_scroll),
		.flip_o       (flip),
		.int_enable_o (int_enable)
	);

	// ====================
	// Timing
	// ====================
	video_timing u_timing (
		.pixel_clk    (pixel_clk),
		.RESET_n      (RESET_n),
		.flip_i       (flip),
		.int_enable_i (int_enable),
		.h_scroll_i   (h_scroll),
		.hpix_o       (hpix),
		.vpix_o       (vpix_o),
		.hpix_scrl_o  (hpix_scrl_o),
		.h_sync_o     (h_sync_o),
		.h_blank_o    (h_blank_o),
		.v_sync_o     (v_sync_o),
		.v_blank_o    (v_blank_o),
		.irq_o        (irq_o)
	);

	// ====================
	// Mixer
	// ====================
	pixel_mixer u_mixer (
		.pixel_clk  (pixel_clk),
		.RESET_n    (RESET_n),
		.hpix_i     (hpix),
		.sp_pixel_i (sp_pixel_i),
		.bg_pixel_i (bg_pixel_i),
		.colour_o   (colour_o)
	);

endmodule

// ==== hdl/pixel_mixer.sv ====
`timescale 1ns/10ps

module pixel_mixer import performan_pkg::*; (
	input  logic   pixel_clk,
	input  logic   RESET_n,
	input  hpix_t  hpix_i,
	input  pixel_t sp_pixel_i,
	input  pixel_t bg_pixel_i,
	output pixel_t colour_o     // Colour PROM address
);

	// ====================
	// Priority
	// ====================
	logic   sp_opaque;
	logic   bg_clear;
	logic   sp_wins;
	logic   in_border;
	pixel_t mix;
	pixel_t colour;

	assign sp_opaque = |sp_pixel_i[2:0];
	assign bg_clear  = (bg_pixel_i[2:0] == 3'b000);

	// Bit 7 of the sprite pixel forces it over the background
	assign sp_wins = sp_opaque && (sp_pixel_i[7] || bg_clear);

	// Sprite colours live in the upper half of the PROM
	assign mix = sp_wins ? {1'b1, sp_pixel_i[6:0]} : bg_pixel_i;

	// Border runs from BORDER_LO up to the top of the 9-bit range
	assign in_border = (hpix_i >= BORDER_LO);

	// ====================
	// Output register
	// ====================
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			colour <= '0;
		end else if (in_border) begin
			colour <= '0;
		end else begin
			colour <= mix;
		end
	end

	assign colour_o = colour;

endmodule

// ==== hdl/video_timing.sv ====
`timescale 1ns/10ps

module video_timing import performan_pkg::*; (
	input  logic  pixel_clk,
	input  logic  RESET_n,
	input  logic  flip_i,
	input  logic  int_enable_i,
	input  data_t h_scroll_i,
	output hpix_t hpix_o,        // Screen position, flip applied
	output vpix_t vpix_o,
	output hpix_t hpix_scrl_o,   // Scrolled position, one cycle late
	output logic  h_sync_o,
	output logic  h_blank_o,
	output logic  v_sync_o,
	output logic  v_blank_o,
	output logic  irq_o
);

	hpix_t hcount;
	vcnt_t vcount;
	logic  line_end;
	logic  frame_end;
	logic  vblank_entry;

	hpix_t hpix;
	hpix_t hpix_flip;
	hpix_t hpix_scrl;
	hpix_t scrl_sum;
	logic  irq;

	// ====================
	// Counters
	// ====================
	assign line_end  = (hcount == H_TOTAL - 9'd1);
	assign frame_end = (vcount == V_TOTAL - 9'd1);

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			hcount <= '0;
		end else if (line_end) begin
			hcount <= '0;
		end else begin
			hcount <= hcount + 9'd1;
		end
	end

	// Line counter steps once per line, on the last pixel clock
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			vcount <= '0;
		end else if (line_end) begin
			if (frame_end) begin
				vcount <= '0;
			end else begin
				vcount <= vcount + 9'd1;
			end
		end
	end

	// ====================
	// Positions and scroll
	// ====================
	assign hpix_flip = H_FLIP_BASE - hcount;  // Wraps mod 512
	assign hpix      = flip_i ? hpix_flip : hcount;

	assign vpix_o = flip_i ? ~vcount[7:0] : vcount[7:0];

	// Scroll bit 8 is tied low on this board
	assign scrl_sum = hpix + {1'b0, h_scroll_i};

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			hpix_scrl <= '0;
		end else begin
			hpix_scrl <= scrl_sum;
		end
	end

	// ====================
	// Sync and blank
	// ====================
	assign h_sync_o  = (hcount >= H_SYNC_START) && (hcount <= H_SYNC_END);
	assign h_blank_o = (hcount >= H_BLANK_START);
	assign v_sync_o  = (vcount >= V_SYNC_START) && (vcount <= V_SYNC_END);
	assign v_blank_o = (vcount >= V_BLANK_START);

	// ====================
	// Vblank interrupt
	// ====================
	// True on the edge that moves vcount onto the first blank line
	assign vblank_entry = line_end && (vcount == V_BLANK_START - 9'd1);

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			irq <= 1'b0;
		end else if (!int_enable_i) begin
			irq <= 1'b0;           // Enable low holds the flop clear
		end else if (vblank_entry) begin
			irq <= 1'b1;
		end
	end

	assign hpix_o      = hpix;
	assign hpix_scrl_o = hpix_scrl;
	assign irq_o       = irq;

endmodule

// ==== hdl/bus_decode.sv ====
`timescale 1ns/10ps

module bus_decode import performan_pkg::*; (
	input  logic  pixel_clk,
	input  logic  RESET_n,
	input  addr_t bus_addr_i,
	input  data_t bus_data_i,
	input  logic  mem_wr_i,      // Memory write strobe
	input  logic  io_wr_i,       // I/O write strobe
	output data_t h_scroll_o,
	output logic  flip_o,
	output logic  int_enable_o
);

	// ====================
	// Address decode
	// ====================
	logic       port_win;
	logic       hscrl_wr;
	logic [2:0] latch_sel;
	logic       latch_d;
	logic       flip_wr;
	logic       int_en_wr;

	data_t h_scroll;
	logic  flip;
	logic  int_enable;

	// Window at 0xA800, 2K wide
	assign port_win = (bus_addr_i[15:11] == MCU_PORT_BASE[15:11]);

	assign hscrl_wr = mem_wr_i && port_win && (bus_addr_i[1:0] == HSCRL_LO_OFS);

	// Addressable latch takes its index and data from the address bus
	assign latch_sel = bus_addr_i[3:1];
	assign latch_d   = bus_addr_i[0];

	assign flip_wr   = io_wr_i && (latch_sel == LATCH_FLIP);
	assign int_en_wr = io_wr_i && (latch_sel == LATCH_INT_ENABLE);

	// ====================
	// Registers
	// ====================
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			h_scroll <= '0;
		end else if (hscrl_wr) begin
			h_scroll <= bus_data_i;  // Low byte only, bit 8 stays 0
		end
	end

	// Only the two latch bits still in use are held
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			flip       <= 1'b0;
			int_enable <= 1'b0;
		end else begin
			if (flip_wr) begin
				flip <= latch_d;
			end
			if (int_en_wr) begin
				int_enable <= latch_d;
			end
		end
	end

	assign h_scroll_o   = h_scroll;
	assign flip_o       = flip;
	assign int_enable_o = int_enable;

endmodule

// ==== hdl/performan_pkg.sv ====
package performan_pkg;

	// ====================
	// Video and bus types
	// ====================
	typedef logic [15:0] addr_t;   // CPU address
	typedef logic [7:0]  data_t;   // CPU data byte
	typedef logic [8:0]  hpix_t;   // Horizontal position
	typedef logic [7:0]  vpix_t;   // Vertical pixel line
	typedef logic [8:0]  vcnt_t;   // Line counter
	typedef logic [7:0]  pixel_t;  // Layer pixel or colour index

	// ====================
	// Horizontal timing
	// ====================
	localparam hpix_t H_TOTAL       = 9'd388;  // Pixel clocks per line
	localparam hpix_t H_SYNC_START  = 9'd320;
	localparam hpix_t H_SYNC_END    = 9'd351;  // Inclusive
	localparam hpix_t H_BLANK_START = 9'd296;  // Blank to end of line

	// Mirrored position is base minus count, wraps at 512
	localparam hpix_t H_FLIP_BASE = 9'd258;

	// Left edge of the forced black border
	localparam hpix_t BORDER_LO = 9'd411;

	// ====================
	// Vertical timing
	// ====================
	localparam vcnt_t V_TOTAL       = 9'd270;  // Lines per frame
	localparam vcnt_t V_BLANK_START = 9'd240;  // Blank to end of frame
	localparam vcnt_t V_SYNC_START  = 9'd248;
	localparam vcnt_t V_SYNC_END    = 9'd255;  // Inclusive

	// ====================
	// CPU bus map
	// ====================
	// Scroll and port window, only bits 15..11 take part in the decode
	localparam addr_t MCU_PORT_BASE = 16'hA800;

	// Low address bits selecting the horizontal scroll register
	localparam logic [1:0] HSCRL_LO_OFS = 2'd0;

	// Bit positions in the addressable control latch
	localparam logic [2:0] LATCH_FLIP       = 3'd1;
	localparam logic [2:0] LATCH_INT_ENABLE = 3'd3;

endpackage
